//--- rtl/perf_pkg.sv
// Assumes two retire lanes and cache state encodings that match the core FSMs
`default_nettype none

package perf_pkg;

  localparam int NRET  = 2;
  localparam int CTR_W = 64;
  // Wide enough to hold a full retire burst
  localparam int INC_W = 2;

  localparam int WB_AW = 8;
  localparam int WB_DW = 32;

  localparam logic [WB_AW-1:0] CTRL_ADDR = 8'h80;
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_CLR_BIT = 1;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_MISS_REQ,
    IC_MISS_WAIT
  } icache_state_e;

  // Encoding 7 is unused
  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_STORE_WRITE,
    DC_WB_REQ,
    DC_MISS_REQ,
    DC_WAIT_REFILL,
    DC_RESP
  } dcache_state_e;

  // Counter index and register map with two words per counter
  typedef enum logic [4:0] {
    CYCLES,
    COMMIT_CYCLES,
    COMMIT_INSTRS,
    NOCOMMIT_CYCLES,
    FE_EMPTY,
    FE_STALL,
    DEC_STALL,
    FLUSH,
    ICACHE_MISS_STALL,
    DCACHE_MISS_STALL,
    ICACHE_IDLE_CYCLES,
    ICACHE_LOOKUP_CYCLES,
    ICACHE_MISS_REQ_CYCLES,
    ICACHE_MISS_WAIT_CYCLES,
    DCACHE_IDLE_CYCLES,
    DCACHE_LOOKUP_CYCLES,
    DCACHE_STORE_WRITE_CYCLES,
    DCACHE_WB_REQ_CYCLES,
    DCACHE_MISS_REQ_CYCLES,
    DCACHE_WAIT_REFILL_CYCLES,
    DCACHE_RESP_CYCLES,
    NUM_CTRS
  } perf_ctr_e;

  typedef struct packed {
    logic [NRET-1:0] commit_valid;
    logic            fe_valid;
    logic            fe_ready;
    logic            dec_valid;
    logic            dec_ready;
    logic            icache_miss_valid;
    logic            icache_miss_ready;
    logic            dcache_miss_valid;
    logic            dcache_miss_ready;
    logic            flush;
    icache_state_e   icache_state;
    dcache_state_e   dcache_state;
  } pipe_status_t;

  typedef logic [NUM_CTRS-1:0][INC_W-1:0] ctr_inc_t;

  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [WB_AW-1:0]   adr;
    logic [WB_DW-1:0]   dat;
    logic [WB_DW/8-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/perf_event_sampler.sv
// Status is sampled every cycle with no handshake; increments lag the status by one cycle
`timescale 1ns/1ps
`default_nettype none

module perf_event_sampler (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  perf_pkg::pipe_status_t status_i,
  input  logic                   count_en_i,
  output perf_pkg::ctr_inc_t     inc_o
);

  import perf_pkg::*;

  logic [INC_W-1:0] n_commit;
  logic             any_commit;
  ctr_inc_t         inc_d;

  // Popcount of the retire mask
  always_comb begin
    n_commit = '0;
    for (int i = 0; i < NRET; i++) begin
      n_commit = n_commit + INC_W'(status_i.commit_valid[i]);
    end
  end

  assign any_commit = |status_i.commit_valid;

  always_comb begin
    inc_d = '0;
    if (count_en_i) begin
      inc_d[CYCLES]          = INC_W'(1);
      inc_d[COMMIT_INSTRS]   = n_commit;
      inc_d[COMMIT_CYCLES]   = INC_W'(any_commit);
      inc_d[NOCOMMIT_CYCLES] = INC_W'(!any_commit);

      inc_d[FE_EMPTY]  = INC_W'(!status_i.fe_valid);
      inc_d[FE_STALL]  = INC_W'(status_i.fe_valid && !status_i.fe_ready);
      inc_d[DEC_STALL] = INC_W'(status_i.dec_valid && !status_i.dec_ready);
      inc_d[FLUSH]     = INC_W'(status_i.flush);

      // Miss request held with no grant
      inc_d[ICACHE_MISS_STALL] =
        INC_W'(status_i.icache_miss_valid && !status_i.icache_miss_ready);
      inc_d[DCACHE_MISS_STALL] =
        INC_W'(status_i.dcache_miss_valid && !status_i.dcache_miss_ready);

      // State counters are laid out in encoding order
      inc_d[int'(ICACHE_IDLE_CYCLES) + int'(status_i.icache_state)] = INC_W'(1);
      if (status_i.dcache_state <= DC_RESP) begin
        inc_d[int'(DCACHE_IDLE_CYCLES) + int'(status_i.dcache_state)] = INC_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inc_o <= '0;
    end else begin
      inc_o <= inc_d;
    end
  end

  // D-cache FSM never reaches the spare encoding
  a_dcache_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    status_i.dcache_state <= DC_RESP
  ) else $error("D-cache state takes unused encoding %0d", status_i.dcache_state);

endmodule

`default_nettype wire

//--- rtl/perf_counter_bank.sv
// Counters wrap at 2^64; clear wins over the increment of the same edge
`timescale 1ns/1ps
`default_nettype none

module perf_counter_bank (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  perf_pkg::ctr_inc_t          inc_i,
  input  logic                        clear_i,
  input  perf_pkg::perf_ctr_e         rd_idx_i,
  output logic [perf_pkg::CTR_W-1:0]  rd_value_o
);

  import perf_pkg::*;

  logic [CTR_W-1:0] ctr_q [NUM_CTRS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= ctr_q[i] + CTR_W'(inc_i[i]);
      end
    end
  end

  // Indices past the last counter read as zero
  always_comb begin
    rd_value_o = '0;
    if (rd_idx_i < NUM_CTRS) begin
      rd_value_o = ctr_q[rd_idx_i];
    end
  end

  // Sampler never hands over more than one retire burst per counter
  for (genvar g = 0; g < NUM_CTRS; g++) begin : g_inc_chk
    a_inc_bound: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      int'(inc_i[g]) <= NRET
    ) else $error("counter %0d increment %0d above retire width", g, inc_i[g]);
  end

endmodule

`default_nettype wire

//--- rtl/perf_wb_regs.sv
// Classic Wishbone single access only; read the low half of a counter before its high half
`timescale 1ns/1ps
`default_nettype none

module perf_wb_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  perf_pkg::wb_req_t          wb_req_i,
  output perf_pkg::wb_rsp_t          wb_rsp_o,
  output perf_pkg::perf_ctr_e        rd_idx_o,
  input  logic [perf_pkg::CTR_W-1:0] rd_value_i,
  output logic                       count_en_o,
  output logic                       clear_o
);

  import perf_pkg::*;

  logic             access;
  logic             is_ctrl;
  logic             is_ctr;
  logic             is_hi;
  logic             ctrl_wr;
  logic             ack_q;
  logic             enable_q;
  logic [WB_DW-1:0] rdata_d;
  logic [WB_DW-1:0] rdata_q;
  logic [WB_DW-1:0] hi_latch_q;

  assign access  = wb_req_i.cyc && wb_req_i.stb;
  assign is_ctrl = (wb_req_i.adr == CTRL_ADDR);
  assign is_ctr  = (wb_req_i.adr < WB_AW'(2 * NUM_CTRS));
  assign is_hi   = wb_req_i.adr[0];

  // Word address pairs map onto one counter
  assign rd_idx_o = perf_ctr_e'(wb_req_i.adr[$bits(perf_ctr_e):1]);

  always_comb begin
    rdata_d = '0;
    if (is_ctrl) begin
      rdata_d[CTRL_EN_BIT] = enable_q;
    end else if (is_ctr) begin
      rdata_d = is_hi ? hi_latch_q : rd_value_i[WB_DW-1:0];
    end
  end

  // Control write lands at the end of the ack cycle
  assign ctrl_wr = ack_q && access && wb_req_i.we && is_ctrl && wb_req_i.sel[0];
  assign clear_o = ctrl_wr && wb_req_i.dat[CTRL_CLR_BIT];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      enable_q <= 1'b1;
    end else begin
      ack_q <= access && !ack_q;
      if (ctrl_wr) begin
        enable_q <= wb_req_i.dat[CTRL_EN_BIT];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !ack_q) begin
      rdata_q <= rdata_d;
    end
    // Snapshot of the upper word keeps a 64-bit read coherent
    if (access && !ack_q && !wb_req_i.we && is_ctr && !is_hi) begin
      hi_latch_q <= rd_value_i[CTR_W-1:WB_DW];
    end
  end

  assign count_en_o   = enable_q;
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

  // Master keeps the strobe up until it has seen ack
  a_ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("ack raised outside an active bus cycle");

endmodule

`default_nettype wire

//--- rtl/perf_monitor_top.sv
// Status reaches a counter read two cycles after it is presented; bus is Wishbone classic
`timescale 1ns/1ps
`default_nettype none

module perf_monitor_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  perf_pkg::pipe_status_t status_i,
  input  perf_pkg::wb_req_t      wb_req_i,
  output perf_pkg::wb_rsp_t      wb_rsp_o
);

  import perf_pkg::*;

  ctr_inc_t         inc;
  logic             count_en;
  logic             clear;
  perf_ctr_e        rd_idx;
  logic [CTR_W-1:0] rd_value;

  perf_event_sampler u_event_sampler (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .status_i   (status_i),
    .count_en_i (count_en),
    .inc_o      (inc)
  );

  perf_counter_bank u_counter_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .inc_i      (inc),
    .clear_i    (clear),
    .rd_idx_i   (rd_idx),
    .rd_value_o (rd_value)
  );

  perf_wb_regs u_wb_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .rd_idx_o   (rd_idx),
    .rd_value_i (rd_value),
    .count_en_o (count_en),
    .clear_o    (clear)
  );

endmodule

`default_nettype wire

//--- verif/perf_monitor_tb.sv
// Stands in for the core; counts stay far below 2^32 so every high half reads zero
`timescale 1ns/1ps
`default_nettype none

module perf_monitor_tb;

  import perf_pkg::*;

  localparam int ACK_TIMEOUT = 20;
  localparam int N_CTR       = int'(NUM_CTRS);

  logic         clk_i;
  logic         rst_ni;
  pipe_status_t status_i;
  wb_req_t      wb_req_i;
  wb_rsp_t      wb_rsp_o;
  logic [31:0]  lcg_state;

  perf_monitor_top u_perf_monitor_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .status_i (status_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // All lanes off, no valid bits, both caches idle
  function automatic pipe_status_t idle_status();
    pipe_status_t s;
    s = '0;
    s.icache_state = IC_IDLE;
    s.dcache_state = DC_IDLE;
    return s;
  endfunction

  task automatic check_ctr(input perf_ctr_e idx, input logic [CTR_W-1:0] got,
                           input logic [CTR_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR ctr_%s got 0x%h expected 0x%h", idx.name(), got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "counter mismatch");
    end
  endtask

  task automatic check_word(input string name, input logic [WB_DW-1:0] got,
                            input logic [WB_DW-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "bus word mismatch");
    end
  endtask

  task automatic wait_ack(input logic [WB_AW-1:0] adr);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!wb_rsp_o.ack) begin
      if (cycles == ACK_TIMEOUT) begin
        $display("The bus did not acknowledge the access to address 0x%h", adr);
        $display("Simulation finished: FAIL");
        $fatal(1, "bus timeout");
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = 1'b1;
    req.adr = adr;
    req.dat = dat;
    req.sel = '1;
    @(posedge clk_i);
    wb_req_i <= req;
    wait_ack(adr);
    // Strobe drops on the ack edge
    @(posedge clk_i);
    wb_req_i <= '0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.adr = adr;
    @(posedge clk_i);
    wb_req_i <= req;
    wait_ack(adr);
    dat = wb_rsp_o.dat;
    @(posedge clk_i);
    wb_req_i <= '0;
  endtask

  task automatic read_ctr(input perf_ctr_e idx, output logic [CTR_W-1:0] value);
    logic [WB_DW-1:0] lo;
    logic [WB_DW-1:0] hi;
    wb_read(WB_AW'(2 * int'(idx)), lo);
    wb_read(WB_AW'(2 * int'(idx) + 1), hi);
    value = {hi, lo};
  endtask

  task automatic set_ctrl(input logic en, input logic clr);
    wb_write(CTRL_ADDR, {30'd0, clr, en});
  endtask

  task automatic drive_status(input pipe_status_t s, input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      status_i <= s;
    end
  endtask

  // Pause, clear, then enable so that no stale increment lands
  task automatic start_counting();
    @(posedge clk_i);
    status_i <= idle_status();
    set_ctrl(1'b0, 1'b0);
    set_ctrl(1'b0, 1'b1);
    set_ctrl(1'b1, 1'b0);
  endtask

  task automatic stop_counting();
    @(posedge clk_i);
    status_i <= idle_status();
    set_ctrl(1'b0, 1'b0);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic test_clear_pause();
    logic [CTR_W-1:0] value;
    logic [WB_DW-1:0] word;
    stop_counting();
    set_ctrl(1'b0, 1'b1);
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < N_CTR; i++) begin
      read_ctr(perf_ctr_e'(i), value);
      check_ctr(perf_ctr_e'(i), value, '0);
    end
    wb_read(CTRL_ADDR, word);
    check_word("ctrl", word, '0);
  endtask

  task automatic test_commit();
    logic [CTR_W-1:0] instrs;
    logic [CTR_W-1:0] ccycles;
    logic [CTR_W-1:0] nocommit;
    logic [CTR_W-1:0] cycles;
    logic [NRET-1:0]  mask;
    pipe_status_t     s;
    int               sum_pop;
    int               nonzero;
    sum_pop = 0;
    nonzero = 0;
    start_counting();
    for (int i = 0; i < 40; i++) begin
      mask = NRET'(lcg_next());
      s = idle_status();
      s.commit_valid = mask;
      drive_status(s, 1);
      sum_pop += $countones(mask);
      if (mask != '0) begin
        nonzero++;
      end
    end
    stop_counting();
    read_ctr(COMMIT_INSTRS, instrs);
    read_ctr(COMMIT_CYCLES, ccycles);
    read_ctr(NOCOMMIT_CYCLES, nocommit);
    read_ctr(CYCLES, cycles);
    check_ctr(COMMIT_INSTRS, instrs, CTR_W'(sum_pop));
    check_ctr(COMMIT_CYCLES, ccycles, CTR_W'(nonzero));
    check_ctr(NOCOMMIT_CYCLES, nocommit, cycles - ccycles);
  endtask

  task automatic test_stalls();
    logic [CTR_W-1:0] value;
    logic [CTR_W-1:0] cycles;
    pipe_status_t     s;
    start_counting();
    s = idle_status();
    s.fe_valid = 1'b1;
    drive_status(s, 5);
    // Granted cycles must not count as stalls
    s.fe_ready = 1'b1;
    drive_status(s, 3);
    s = idle_status();
    s.dec_valid = 1'b1;
    drive_status(s, 4);
    s.dec_ready = 1'b1;
    drive_status(s, 2);
    s = idle_status();
    s.icache_miss_valid = 1'b1;
    drive_status(s, 6);
    s.icache_miss_ready = 1'b1;
    drive_status(s, 2);
    s = idle_status();
    s.dcache_miss_valid = 1'b1;
    drive_status(s, 7);
    s.dcache_miss_ready = 1'b1;
    drive_status(s, 2);
    s = idle_status();
    s.flush = 1'b1;
    drive_status(s, 3);
    stop_counting();
    read_ctr(FE_STALL, value);
    check_ctr(FE_STALL, value, 64'd5);
    read_ctr(DEC_STALL, value);
    check_ctr(DEC_STALL, value, 64'd4);
    read_ctr(ICACHE_MISS_STALL, value);
    check_ctr(ICACHE_MISS_STALL, value, 64'd6);
    read_ctr(DCACHE_MISS_STALL, value);
    check_ctr(DCACHE_MISS_STALL, value, 64'd7);
    read_ctr(FLUSH, value);
    check_ctr(FLUSH, value, 64'd3);
    // Frontend held valid for eight cycles in total
    read_ctr(CYCLES, cycles);
    read_ctr(FE_EMPTY, value);
    check_ctr(FE_EMPTY, value, cycles - 64'd8);
  endtask

  task automatic test_states();
    logic [CTR_W-1:0] value;
    logic [CTR_W-1:0] cycles;
    logic [CTR_W-1:0] ic_sum;
    logic [CTR_W-1:0] dc_sum;
    pipe_status_t     s;
    ic_sum = '0;
    dc_sum = '0;
    start_counting();
    s = idle_status();
    s.icache_state = IC_MISS_WAIT;
    drive_status(s, 9);
    s = idle_status();
    s.dcache_state = DC_WAIT_REFILL;
    drive_status(s, 6);
    stop_counting();
    read_ctr(CYCLES, cycles);
    for (int i = int'(ICACHE_IDLE_CYCLES); i <= int'(ICACHE_MISS_WAIT_CYCLES); i++) begin
      read_ctr(perf_ctr_e'(i), value);
      ic_sum += value;
      if (perf_ctr_e'(i) == ICACHE_MISS_WAIT_CYCLES) begin
        check_ctr(perf_ctr_e'(i), value, 64'd9);
      end else if (perf_ctr_e'(i) != ICACHE_IDLE_CYCLES) begin
        check_ctr(perf_ctr_e'(i), value, '0);
      end
    end
    for (int i = int'(DCACHE_IDLE_CYCLES); i <= int'(DCACHE_RESP_CYCLES); i++) begin
      read_ctr(perf_ctr_e'(i), value);
      dc_sum += value;
      if (perf_ctr_e'(i) == DCACHE_WAIT_REFILL_CYCLES) begin
        check_ctr(perf_ctr_e'(i), value, 64'd6);
      end else if (perf_ctr_e'(i) != DCACHE_IDLE_CYCLES) begin
        check_ctr(perf_ctr_e'(i), value, '0);
      end
    end
    check_ctr(CYCLES, ic_sum, cycles);
    check_ctr(CYCLES, dc_sum, cycles);
  endtask

  task automatic test_pause_map();
    logic [CTR_W-1:0] snap [N_CTR];
    logic [CTR_W-1:0] value;
    logic [WB_DW-1:0] word;
    pipe_status_t     s;
    for (int i = 0; i < N_CTR; i++) begin
      read_ctr(perf_ctr_e'(i), snap[i]);
    end
    s = idle_status();
    s.commit_valid = '1;
    s.fe_valid     = 1'b1;
    s.flush        = 1'b1;
    s.icache_state = IC_LOOKUP;
    s.dcache_state = DC_RESP;
    drive_status(s, 8);
    @(posedge clk_i);
    status_i <= idle_status();
    wb_write(8'h60, 32'hffff_ffff);
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < N_CTR; i++) begin
      read_ctr(perf_ctr_e'(i), value);
      check_ctr(perf_ctr_e'(i), value, snap[i]);
    end
    wb_read(8'h60, word);
    check_word("unmapped_0x60", word, '0);
    wb_read(8'hff, word);
    check_word("unmapped_0xff", word, '0);
    // Low read while counting, then the latched upper word
    set_ctrl(1'b1, 1'b0);
    wb_read(WB_AW'(2 * int'(CYCLES)), word);
    wb_read(WB_AW'(2 * int'(CYCLES) + 1), word);
    check_word("ctr_CYCLES_hi", word, '0);
    stop_counting();
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    status_i  = idle_status();
    wb_req_i  = '0;
    lcg_state = 32'd83;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_clear_pause();
    test_commit();
    test_stalls();
    test_states();
    test_pause_map();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rtl/perf_pkg.sv
rtl/perf_event_sampler.sv
rtl/perf_counter_bank.sv
rtl/perf_wb_regs.sv
rtl/perf_monitor_top.sv
verif/perf_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and passes only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f build.f --top-module perf_monitor_tb \
  -o perf_sim &&
./obj_dir/perf_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
